// File: src.f
+incdir+common
common/miner_pkg.sv
hdl/round_dispatcher.sv
hash_core/hash_core.sv
hash_core/core_array.sv
hdl/nonce_decoder.sv
hdl/miner_top.sv
testbench/miner_chk.sv
testbench/miner_tb.sv

// File: run.sh
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log &&
verilator --binary --timing --assert --top-module miner_tb -Mdir obj_dir -f src.f &&
{ ./obj_dir/Vminer_tb 2>&1 | tee sim.log; } &&
grep -q "Regression passed" sim.log &&
echo "simulation passed" ||
{ echo "simulation failed"; exit 1; }

// File: testbench/miner_tb.sv
`default_nettype none

`include "miner_consts.svh"

module miner_tb;

	localparam int RESET_CYCLES   = 16;
	localparam int RESULT_LAT     = `BROADCAST_CNT + `HASH_LAT + 1;
	localparam int TIMEOUT_CYCLES = 40 * (`BROADCAST_CNT + `HASH_LAT + 8) + RESET_CYCLES;

	typedef struct packed {
		logic        success;
		logic [31:0] nonce;
	} search_t;

	// one awaited result pulse and the falling edge count where it should be seen
	typedef struct packed {
		search_t     res;
		logic        check_nonce;
		logic [31:0] cycle;
	} expect_t;

	logic        clk;
	logic        rst_n_i;
	logic        block_valid_i;
	logic [31:0] block_word_i;
	logic        busy_o;
	logic        result_valid_o;
	logic        result_success_o;
	logic [31:0] result_nonce_o;

	int unsigned cycle_cnt = 0;
	int          pulse_cnt = 0;
	int          expected_pulses = 0;
	logic [31:0] rng_state = 32'd16;
	expect_t     exp_q[$];

	miner_top dut_i (
		.clk              (clk),
		.rst_n_i          (rst_n_i),
		.block_valid_i    (block_valid_i),
		.block_word_i     (block_word_i),
		.busy_o           (busy_o),
		.result_valid_o   (result_valid_o),
		.result_success_o (result_success_o),
		.result_nonce_o   (result_nonce_o)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	function automatic logic [31:0] lcg_next(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	function automatic logic nonce_hits(input logic [31:0] word, input logic [31:0] nonce);
		logic [31:0] p;
		p = (word ^ nonce) * `MIX_CONST;
		p = p ^ (p >> 16);
		return p[`ZERO_BITS-1:0] == '0;
	endfunction

	// a later round with a hit replaces the answer of an earlier one
	function automatic search_t search_block(input logic [31:0] word, output int hit_rounds);
		search_t res;
		logic    round_hit;
		res = '0;
		hit_rounds = 0;
		for (int r = 0; r < `BROADCAST_CNT; r++) begin
			round_hit = 1'b0;
			for (int c = 0; c < `NUM_CORES; c++) begin
				if (!round_hit && nonce_hits(word, 32'(r * `NUM_CORES + c))) begin
					round_hit   = 1'b1;
					res.success = 1'b1;
					res.nonce   = 32'(r * `NUM_CORES + c);
				end
			end
			if (round_hit)
				hit_rounds++;
		end
		return res;
	endfunction

	task automatic stop_with_failure();
		$display("Regression failed");
		$fatal(1, "simulation stopped at time %0t", $time);
	endtask

	task automatic check_value(input string what, input logic [31:0] got,
			input logic [31:0] exp);
		if (got !== exp) begin
			$display("Mismatch at time %0t: %s is %h, expected %h", $time, what, got, exp);
			stop_with_failure();
		end
	endtask

	task automatic strobe_block(input logic [31:0] word, input logic expect_result);
		expect_t e;
		int      hit_rounds;
		@(posedge clk);
		block_valid_i <= 1'b1;
		block_word_i  <= word;
		if (expect_result) begin
			e.res         = search_block(word, hit_rounds);
			e.check_nonce = e.res.success;
			// the pulse is sampled on the falling edge one count after its rising edge
			e.cycle       = cycle_cnt + RESULT_LAT + 1;
			exp_q.push_back(e);
			expected_pulses++;
		end
		@(posedge clk);
		block_valid_i <= 1'b0;
		// the dispatcher sends rounds from the edge that took the strobe
		@(negedge clk);
		check_value("busy while issuing", 32'(busy_o), 32'd1);
	endtask

	task automatic wait_for_results();
		while (pulse_cnt < expected_pulses)
			@(posedge clk);
	endtask

	// walks the random sequence until a word has the wanted number of hitting rounds
	task automatic find_word(input int min_rounds, input int max_rounds,
			output logic [31:0] word);
		int hit_rounds;
		int tries;
		tries = 0;
		do begin
			rng_state = lcg_next(rng_state);
			word = rng_state;
			void'(search_block(word, hit_rounds));
			tries++;
		end while ((hit_rounds < min_rounds || hit_rounds > max_rounds) && tries < 1000);
		if (hit_rounds < min_rounds || hit_rounds > max_rounds) begin
			$display("No block word with %0d to %0d hitting rounds was found",
				min_rounds, max_rounds);
			stop_with_failure();
		end
	endtask

	always @(negedge clk) begin : compare_results
		expect_t cur;
		cycle_cnt = cycle_cnt + 1;
		if (cycle_cnt > TIMEOUT_CYCLES) begin
			$display("Timeout: the run did not end within %0d cycles", TIMEOUT_CYCLES);
			stop_with_failure();
		end
		if (rst_n_i && result_valid_o !== 1'b0) begin
			if (exp_q.size() == 0) begin
				$display("A result pulse came at time %0t with no block waiting for it", $time);
				stop_with_failure();
			end else begin
				cur = exp_q.pop_front();
				check_value("result cycle", cycle_cnt, cur.cycle);
				check_value("result success", 32'(result_success_o), 32'(cur.res.success));
				if (cur.check_nonce)
					check_value("result nonce", result_nonce_o, cur.res.nonce);
				pulse_cnt++;
			end
		end
	end

	initial begin : stimulus
		logic [31:0] word_a;
		logic [31:0] word_b;
		rst_n_i       <= 1'b0;
		block_valid_i <= 1'b0;
		block_word_i  <= '0;
		repeat (RESET_CYCLES) @(posedge clk);
		rst_n_i <= 1'b1;

		// nothing moves until the first block arrives
		repeat (12) begin
			@(negedge clk);
			check_value("busy before any block", 32'(busy_o), 32'd0);
			check_value("result valid before any block", 32'(result_valid_o), 32'd0);
			check_value("success before any block", 32'(result_success_o), 32'd0);
			check_value("nonce before any block", result_nonce_o, 32'd0);
		end

		for (int b = 0; b < 30; b++) begin
			rng_state = lcg_next(rng_state);
			strobe_block(rng_state, 1'b1);
			wait_for_results();
		end

		find_word(0, 0, word_a);
		strobe_block(word_a, 1'b1);
		wait_for_results();

		find_word(2, `BROADCAST_CNT, word_a);
		strobe_block(word_a, 1'b1);
		wait_for_results();

		// the second strobe lands while the first block is still issuing rounds
		rng_state = lcg_next(rng_state);
		word_a = rng_state;
		rng_state = lcg_next(rng_state);
		word_b = rng_state;
		strobe_block(word_a, 1'b0);
		repeat (3) @(posedge clk);
		strobe_block(word_b, 1'b1);
		wait_for_results();
		// long enough for a stray pulse of the first block to show up
		repeat (RESULT_LAT + 4) @(posedge clk);

		if (exp_q.size() == 0 && pulse_cnt == expected_pulses) begin
			$display("Regression passed");
			$finish;
		end else begin
			$display("%0d result pulses seen where %0d were expected",
				pulse_cnt, expected_pulses);
			stop_with_failure();
		end
	end

endmodule

`default_nettype wire

// File: testbench/miner_chk.sv
`default_nettype none

`include "miner_consts.svh"

module miner_chk (
	input logic clk,
	input logic rst_n_i,
	input logic busy_i,
	input logic result_valid_i,
	input logic result_success_i
);

	localparam int QUIET_CYCLES = `HASH_LAT + 1;

	// number of samples in a row with busy low that saturates at its top value
	logic [7:0] quiet_run_q;

	always_ff @(posedge clk) begin
		if (!rst_n_i || busy_i)
			quiet_run_q <= '0;
		else if (quiet_run_q != 8'hFF)
			quiet_run_q <= quiet_run_q + 8'd1;
	end

	a_single_pulse: assert property (@(posedge clk) disable iff (!rst_n_i)
		result_valid_i |=> !result_valid_i)
		else $error("result valid was high on two cycles in a row");

	a_quiet_before_result: assert property (@(posedge clk) disable iff (!rst_n_i)
		result_valid_i |-> quiet_run_q >= 8'(QUIET_CYCLES))
		else $error("busy was not low long enough before a result pulse");

	a_no_success_in_reset: assert property (@(posedge clk)
		(!rst_n_i && $past(!rst_n_i)) |-> !result_success_i)
		else $error("result success was high during reset");

endmodule

bind miner_top miner_chk u_chk (
	.clk              (clk),
	.rst_n_i          (rst_n_i),
	.busy_i           (busy_o),
	.result_valid_i   (result_valid_o),
	.result_success_i (result_success_o)
);

`default_nettype wire

// File: hdl/miner_top.sv
`default_nettype none

module miner_top (
	input  logic        clk,
	input  logic        rst_n_i,
	input  logic        block_valid_i,
	input  logic [31:0] block_word_i,
	output logic        busy_o,
	output logic        result_valid_o,
	output logic        result_success_o,
	output logic [31:0] result_nonce_o
);

	miner_pkg::round_t       round;
	miner_pkg::core_result_t core_result;

	round_dispatcher u_dispatcher (
		.clk           (clk),
		.rst_n_i       (rst_n_i),
		.block_valid_i (block_valid_i),
		.block_word_i  (block_word_i),
		.round_o       (round),
		.busy_o        (busy_o)
	);

	core_array u_cores (
		.clk      (clk),
		.rst_n_i  (rst_n_i),
		.round_i  (round),
		.result_o (core_result)
	);

	// decoder keeps its default sizes, which come from the shared constants
	nonce_decoder u_decoder (
		.clk       (clk),
		.rst_n_i   (rst_n_i),
		.result_i  (core_result),
		.valid_o   (result_valid_o),
		.success_o (result_success_o),
		.nonce_o   (result_nonce_o)
	);

endmodule

`default_nettype wire

// File: hdl/nonce_decoder.sv
`default_nettype none

`include "miner_consts.svh"

module nonce_decoder #(
	parameter int NUM_CORES     = `NUM_CORES,
	parameter int BROADCAST_CNT = `BROADCAST_CNT
) (
	input  logic                     clk,
	input  logic                     rst_n_i,
	input  miner_pkg::core_result_t  result_i,
	output logic                     valid_o,
	output logic                     success_o,
	output logic [31:0]              nonce_o
);

	localparam logic [31:0] STEP   = 32'(NUM_CORES);
	localparam logic [31:0] TARGET = 32'(NUM_CORES * BROADCAST_CNT);

	logic        reading_q;
	logic        reading_d;
	logic [31:0] count_q;
	logic [31:0] count_d;
	logic        in_block;
	logic        last_q;
	logic        last_d;
	logic        found;
	logic [31:0] nonce_q;
	logic [31:0] nonce_d;
	logic        success_q;
	logic        success_d;

	// nonce base of the round now at the input
	always_comb begin
		if (!result_i.valid)
			count_d = count_q;
		else if (result_i.newblock)
			count_d = '0;
		else
			count_d = count_q + STEP;
	end

	// a newblock round opens the block even if the previous one never finished
	assign in_block = result_i.valid && (result_i.newblock || reading_q);

	// reading drops once this round is the final one of the block
	always_comb begin
		if (!result_i.valid)
			reading_d = reading_q;
		else
			reading_d = in_block && ((count_d + STEP) < TARGET);
	end

	assign last_d = in_block && ((count_d + STEP) == TARGET);

	assign found   = in_block && result_i.success;
	assign nonce_d = found ? (count_d + 32'(result_i.processor_index)) : nonce_q;

	// success sticks until the result pulse, a new block starts it afresh
	always_comb begin
		if (result_i.valid && result_i.newblock)
			success_d = result_i.success;
		else
			success_d = found || (success_q && !last_q);
	end

	always_ff @(posedge clk) begin
		if (!rst_n_i) begin
			reading_q <= 1'b0;
			count_q   <= '0;
			last_q    <= 1'b0;
			nonce_q   <= '0;
			success_q <= 1'b0;
		end else begin
			reading_q <= reading_d;
			count_q   <= count_d;
			last_q    <= last_d;
			nonce_q   <= nonce_d;
			success_q <= success_d;
		end
	end

	assign valid_o   = last_q;
	assign success_o = success_q;
	assign nonce_o   = nonce_q;

endmodule

`default_nettype wire

// File: hash_core/core_array.sv
`default_nettype none

`include "miner_consts.svh"

module core_array (
	input  logic                     clk,
	input  logic                     rst_n_i,
	input  miner_pkg::round_t        round_i,
	output miner_pkg::core_result_t  result_o
);

	logic [`NUM_CORES-1:0] hits;
	logic [`NUM_CORES-1:0] hits_gated;
	logic [`HASH_LAT-1:0]  valid_sr;
	logic [`HASH_LAT-1:0]  newblock_sr;

	for (genvar i = 0; i < `NUM_CORES; i++) begin : g_core
		hash_core u_core (
			.clk          (clk),
			.rst_n_i      (rst_n_i),
			.block_word_i (round_i.block_word),
			.nonce_i      (round_i.nonce_base + 32'(i)),
			.hit_o        (hits[i])
		);
	end

	// round control follows the core pipeline so it lines up with the hits
	always_ff @(posedge clk) begin
		if (!rst_n_i) begin
			valid_sr    <= '0;
			newblock_sr <= '0;
		end else begin
			valid_sr[0]    <= round_i.valid;
			newblock_sr[0] <= round_i.newblock;
			for (int k = 1; k < `HASH_LAT; k++) begin
				valid_sr[k]    <= valid_sr[k-1];
				newblock_sr[k] <= newblock_sr[k-1];
			end
		end
	end

	assign hits_gated = hits & {`NUM_CORES{valid_sr[`HASH_LAT-1]}};

	// lowest core index wins, so scan from the top down
	always_comb begin
		result_o.valid           = valid_sr[`HASH_LAT-1];
		result_o.newblock        = newblock_sr[`HASH_LAT-1];
		result_o.success         = |hits_gated;
		result_o.processor_index = '0;
		for (int i = `NUM_CORES - 1; i >= 0; i--) begin
			if (hits_gated[i])
				result_o.processor_index = 8'(i);
		end
	end

endmodule

`default_nettype wire

// File: hash_core/hash_core.sv
`default_nettype none

`include "miner_consts.svh"

module hash_core (
	input  logic        clk,
	input  logic        rst_n_i,
	input  logic [31:0] block_word_i,
	input  logic [31:0] nonce_i,
	output logic        hit_o
);

	logic [31:0] mixed;
	logic [31:0] mix_q;
	logic [31:0] hash;
	logic        hit_q;

	// first half of the hash, xor then multiply and keep the low word
	assign mixed = (block_word_i ^ nonce_i) * `MIX_CONST;

	// stage one
	always_ff @(posedge clk) begin
		mix_q <= mixed;
	end

	// fold the upper half back into the lower one
	assign hash = mix_q ^ (mix_q >> 16);

	// stage two holds only the verdict, the hash value itself is not needed
	always_ff @(posedge clk) begin
		if (!rst_n_i) begin
			hit_q <= 1'b0;
		end else begin
			hit_q <= (hash[`ZERO_BITS-1:0] == '0);
		end
	end

	assign hit_o = hit_q;

endmodule

`default_nettype wire

// File: hdl/round_dispatcher.sv
`default_nettype none

`include "miner_consts.svh"

module round_dispatcher (
	input  logic               clk,
	input  logic               rst_n_i,
	input  logic               block_valid_i,
	input  logic [31:0]        block_word_i,
	output miner_pkg::round_t  round_o,
	output logic               busy_o
);

	localparam int CNT_W = $clog2(`BROADCAST_CNT + 1);

	miner_pkg::disp_state_e state_q;
	logic [CNT_W-1:0] issued_q;
	logic [CNT_W-1:0] issued_next;
	logic valid_q;
	logic newblock_q;
	logic [31:0] block_word_q;
	logic [31:0] nonce_base_q;

	// issued_q counts rounds already loaded into the round register
	assign issued_next = issued_q + CNT_W'(1);

	always_ff @(posedge clk) begin
		if (!rst_n_i) begin
			state_q    <= miner_pkg::IDLE;
			issued_q   <= '0;
			valid_q    <= 1'b0;
			newblock_q <= 1'b0;
		end else if (block_valid_i) begin
			// a strobe restarts the search, even in the middle of one
			issued_q   <= CNT_W'(1);
			valid_q    <= 1'b1;
			newblock_q <= 1'b1;
			if (`BROADCAST_CNT > 1)
				state_q <= miner_pkg::ISSUE;
			else
				state_q <= miner_pkg::IDLE;
		end else begin
			newblock_q <= 1'b0;
			case (state_q)
				miner_pkg::ISSUE: begin
					valid_q  <= 1'b1;
					issued_q <= issued_next;
					// leave ISSUE on the edge that loads the last round
					if (issued_next == CNT_W'(`BROADCAST_CNT))
						state_q <= miner_pkg::IDLE;
				end
				default: begin
					valid_q <= 1'b0;
				end
			endcase
		end
	end

	// block word and nonce base are only meaningful while valid_q is set
	always_ff @(posedge clk) begin
		if (block_valid_i) begin
			block_word_q <= block_word_i;
			nonce_base_q <= '0;
		end else if (state_q == miner_pkg::ISSUE) begin
			nonce_base_q <= nonce_base_q + 32'(`NUM_CORES);
		end
	end

	assign round_o = '{
		valid:      valid_q,
		newblock:   newblock_q,
		block_word: block_word_q,
		nonce_base: nonce_base_q
	};

	assign busy_o = (state_q == miner_pkg::ISSUE);

endmodule

`default_nettype wire

// File: common/miner_pkg.sv
`default_nettype none

package miner_pkg;

	// one round as it leaves the dispatcher
	// core i of this round tries nonce_base + i
	typedef struct packed {
		logic        valid;
		logic        newblock;
		logic [31:0] block_word;
		logic [31:0] nonce_base;
	} round_t;

	// outcome of one round once it has passed through the cores
	typedef struct packed {
		logic       valid;
		logic       newblock;
		logic       success;
		logic [7:0] processor_index;
	} core_result_t;

	// the dispatcher is either waiting for a block or sending its rounds
	typedef enum logic {
		IDLE,
		ISSUE
	} disp_state_e;

endpackage

`default_nettype wire

// File: common/miner_consts.svh
`ifndef MINER_CONSTS_SVH
`define MINER_CONSTS_SVH

// number of hash cores working side by side on one round
`define NUM_CORES 4

// rounds sent to the core array for every block word
`define BROADCAST_CNT 8

// a hash is a hit when this many low bits are zero
`define ZERO_BITS 4

// odd multiplier of the toy mixing hash
`define MIX_CONST 32'h9E37_79B1

// pipeline depth of one hash core
`define HASH_LAT 2

`endif
